//--- smt_mem_path.f
src/smt_mem_pkg.sv
src/mem_req_if.sv
src/thread_mem_arbiter.sv
src/mem_port_switch.sv
src/wfi_tracker.sv
src/smt_mem_path.sv
testbench/smt_mem_path_props.sv
testbench/tb_smt_mem_path.sv

//--- testbench/tb_smt_mem_path.sv
// ----------------------------------------
// Testbench for the SMT memory path.
// Runs a table of thread and fetch requests
// against a random-latency memory model,
// checks grant order and read data, then
// walks the WFI dispatch gating
// ----------------------------------------
`timescale 1ns/1ps

module tb_smt_mem_path;

    localparam int THREAD_NUM = smt_mem_pkg::THREAD_NUM_DEF;
    localparam int RT_NUM     = smt_mem_pkg::RT_NUM_DEF;
    localparam int TIMEOUT    = 50;     // Cycles per handshake wait
    localparam int ROW_NUM    = 10;
    localparam smt_mem_pkg::data_t FILL_KEY = 64'h5a5a_c3c3_0f0f_9696;

    // Threads are sources 0 and 1 and fetch is source 2
    // Grant order digits run low first
    typedef struct {
        string              name;
        logic [2:0]         mask;       // {fetch, t1, t0}
        smt_mem_pkg::addr_t addr;       // Source s adds s*'h100 to this base
        logic               we;         // Threads only
        smt_mem_pkg::data_t wdata;
        logic [11:0]        order;      // Expected grant order at memory
    } row_t;

    logic                                clk_i = 1'b0;
    logic                                rst_n_i;
    logic                                exception_i;
    logic               [THREAD_NUM-1:0] ld_req_i;
    logic               [THREAD_NUM-1:0] ld_we_i;
    smt_mem_pkg::addr_t [THREAD_NUM-1:0] ld_addr_i;
    smt_mem_pkg::data_t [THREAD_NUM-1:0] ld_wdata_i;
    logic               [THREAD_NUM-1:0] ld_ack_o;
    smt_mem_pkg::data_t                  ld_rdata_o;
    logic                                if_req_i;
    smt_mem_pkg::addr_t                  if_addr_i;
    logic                                if_ack_o;
    smt_mem_pkg::data_t                  if_rdata_o;
    logic                                mem_req_o;
    logic                                mem_we_o;
    smt_mem_pkg::addr_t                  mem_addr_o;
    smt_mem_pkg::data_t                  mem_wdata_o;
    logic                                mem_ack_i;
    smt_mem_pkg::data_t                  mem_rdata_i;
    logic [THREAD_NUM-1:0][RT_NUM-1:0]   rt_valid_i;
    logic [THREAD_NUM-1:0][RT_NUM-1:0]   rt_wfi_i;
    logic [THREAD_NUM-1:0]               dp_en_o;

    smt_mem_pkg::data_t mem_store [smt_mem_pkg::addr_t];   // Written words
    smt_mem_pkg::addr_t grant_q [$];                        // Addresses seen at memory
    row_t               rows [ROW_NUM];
    int                 seed = 32'h49db6eaa;

    smt_mem_path #(.THREAD_NUM(THREAD_NUM), .RT_NUM(RT_NUM)) i_dut (.*);

    always #2 clk_i = ~clk_i;  // 4 ns period

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            fail_stop($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // Last written value or the address XOR key
    function automatic smt_mem_pkg::data_t read_model(input smt_mem_pkg::addr_t a);
        if (mem_store.exists(a)) begin
            return mem_store[a];
        end
        return smt_mem_pkg::data_t'(a) ^ FILL_KEY;
    endfunction

    function automatic smt_mem_pkg::addr_t src_addr(input smt_mem_pkg::addr_t base,
                                                    input int src);
        return base + smt_mem_pkg::addr_t'(src) * 32'h100;
    endfunction

    function automatic logic src_ack(input int src);
        return (src == 2) ? if_ack_o : ld_ack_o[src];
    endfunction

    // Bound checker failures
    always @(negedge clk_i) begin
        if (i_dut.i_props.fail_cnt != 0) begin
            fail_stop("a protocol assertion failed during the run");
        end
    end

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    initial begin : mem_model
        smt_mem_pkg::addr_t a;
        logic               wr;
        smt_mem_pkg::data_t wd;
        int unsigned        d;
        int unsigned        cnt;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i === 1'b1 && mem_req_o) begin
                a  = mem_addr_o;
                wr = mem_we_o;
                wd = mem_wdata_o;
                grant_q.push_back(a);
                d = $unsigned($random(seed)) % 4;   // 0 to 3 cycles of latency
                repeat (d) @(posedge clk_i);
                @(posedge clk_i);
                #1;
                if (wr) begin
                    mem_store[a] = wd;
                    mem_rdata_i  = '0;
                end else begin
                    mem_rdata_i = read_model(a);
                end
                mem_ack_i = 1'b1;
                cnt = 0;
                do begin
                    @(negedge clk_i);
                    cnt++;
                    if (cnt > TIMEOUT) fail_stop("memory request stayed high after ack");
                end while (mem_req_o);
                @(posedge clk_i);
                #1;
                mem_ack_i = 1'b0;
            end
        end
    end

    // One four-phase exchange from one source
    task automatic run_source(input int src, input row_t r);
        smt_mem_pkg::addr_t a;
        smt_mem_pkg::data_t exp_data;
        logic               wr;
        int unsigned        cnt;
        a        = src_addr(r.addr, src);
        wr       = (src == 2) ? 1'b0 : r.we;
        exp_data = read_model(a);
        if (src == 2) begin
            @(posedge clk_i);       // One stage late so it meets data at the switch
            #1;
            if_addr_i = a;
            if_req_i  = 1'b1;
        end else begin
            ld_addr_i[src]  = a;
            ld_we_i[src]    = wr;
            ld_wdata_i[src] = r.wdata;
            ld_req_i[src]   = 1'b1;
        end
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_stop($sformatf("source %0d got no ack in %s", src, r.name));
            end
        end while (!src_ack(src));
        check({r.name, "_ack_addr"}, a, mem_addr_o);    // Own request is at memory
        check({r.name, "_ack_we"}, wr, mem_we_o);
        if (wr) begin
            check({r.name, "_wdata"}, r.wdata, mem_wdata_o);
        end else begin
            check({r.name, "_rdata"}, exp_data, (src == 2) ? if_rdata_o : ld_rdata_o);
        end
        @(posedge clk_i);
        #1;
        if (src == 2) if_req_i = 1'b0;
        else ld_req_i[src] = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_stop($sformatf("source %0d ack stuck high in %s", src, r.name));
            end
        end while (src_ack(src));
    endtask

    task automatic check_order(input row_t r);
        int n;
        int src;
        n = $countones(r.mask);
        check({r.name, "_grant_cnt"}, n, grant_q.size());
        for (int k = 0; k < n; k++) begin
            src = (r.order >> (4 * k)) & 12'hf;
            check({r.name, "_grant_order"}, src_addr(r.addr, src), grant_q[k]);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n_i     = 1'b0;
        exception_i = 1'b0;
        ld_req_i    = '0;
        ld_we_i     = '0;
        ld_addr_i   = '0;
        ld_wdata_i  = '0;
        if_req_i    = 1'b0;
        if_addr_i   = '0;
        rt_valid_i  = '0;
        rt_wfi_i    = '0;

        rows[0] = '{"t0_write",        3'b001, 32'h1000, 1'b1, 64'h1111_2222_3333_4444, 12'h0};
        rows[1] = '{"t0_read",         3'b001, 32'h1000, 1'b0, 64'h0, 12'h0};
        rows[2] = '{"t1_read_fill",    3'b010, 32'h2000, 1'b0, 64'h0, 12'h1};
        rows[3] = '{"t1_write",        3'b010, 32'h2000, 1'b1, 64'hdead_beef_0bad_f00d, 12'h1};
        rows[4] = '{"both_same_cycle", 3'b011, 32'h2000, 1'b0, 64'h0, 12'h10};
        rows[5] = '{"t0_single",       3'b001, 32'h3000, 1'b1, 64'h0123_4567_89ab_cdef, 12'h0};
        rows[6] = '{"both_rotate",     3'b011, 32'h3000, 1'b0, 64'h0, 12'h01};   // t1 first
        rows[7] = '{"tie_fetch_first", 3'b101, 32'h4000, 1'b0, 64'h0, 12'h02};
        rows[8] = '{"fetch_only",      3'b100, 32'h5000, 1'b0, 64'h0, 12'h2};
        rows[9] = '{"tie_data_first",  3'b110, 32'h2000, 1'b0, 64'h0, 12'h21};

        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check("reset_mem_req", 1'b0, mem_req_o);
        check("reset_ld_ack", '0, ld_ack_o);
        check("reset_if_ack", 1'b0, if_ack_o);
        check("reset_dp_en", {THREAD_NUM{1'b1}}, dp_en_o);

        for (int i = 0; i < ROW_NUM; i++) begin
            @(posedge clk_i);
            #1;
            grant_q.delete();
            fork
                if (rows[i].mask[0]) run_source(0, rows[i]);
                if (rows[i].mask[1]) run_source(1, rows[i]);
                if (rows[i].mask[2]) run_source(2, rows[i]);
            join
            check_order(rows[i]);
        end

        // WFI on thread 0 and an invalid WFI lane on thread 1
        @(posedge clk_i);
        #1;
        rt_valid_i[0] = 2'b10;
        rt_wfi_i[0]   = 2'b10;
        rt_valid_i[1] = 2'b01;
        rt_wfi_i[1]   = 2'b10;
        @(negedge clk_i);
        check("wfi_retire_cycle", 2'b10, dp_en_o);
        @(posedge clk_i);
        #1;
        rt_valid_i = '0;
        rt_wfi_i   = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check("wfi_held", 2'b10, dp_en_o);
        @(posedge clk_i);
        #1;
        exception_i = 1'b1;
        @(negedge clk_i);
        check("wfi_exception_cycle", 2'b10, dp_en_o);  // Clears on the edge
        @(posedge clk_i);
        #1;
        exception_i = 1'b0;
        @(negedge clk_i);
        check("wfi_cleared", 2'b11, dp_en_o);

        if (i_dut.i_props.fail_cnt != 0) begin
            fail_stop("a protocol assertion failed during the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- testbench/smt_mem_path_props.sv
// ----------------------------------------
// Protocol assertions on the top-level
// memory and ack ports, bound into every
// instance of the SMT memory path
// ----------------------------------------
`timescale 1ns/1ps

module smt_mem_path_props #(
    parameter int THREAD_NUM = smt_mem_pkg::THREAD_NUM_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  mem_req_o,
    input  logic                  mem_ack_i,
    input  smt_mem_pkg::addr_t    mem_addr_o,
    input  logic [THREAD_NUM-1:0] ld_ack_o,
    input  logic                  if_ack_o
);

    int unsigned fail_cnt = 0;  // Failed assertions so far

    // Request held until memory answers
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o)
        else begin
            fail_cnt++;
            $error("mem_req_o dropped before mem_ack_i");
        end

    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> $stable(mem_addr_o))  // Address frozen while waiting
        else begin
            fail_cnt++;
            $error("mem_addr_o changed while a request waited");
        end

    // Ack goes to one requester at a time
    one_ld_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(ld_ack_o))
        else begin
            fail_cnt++;
            $error("more than one ld_ack_o bit high");
        end

    ld_if_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|ld_ack_o) && if_ack_o))
        else begin
            fail_cnt++;
            $error("ld_ack_o and if_ack_o high together");
        end

endmodule

bind smt_mem_path smt_mem_path_props #(.THREAD_NUM(THREAD_NUM)) i_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_req_o  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .mem_addr_o (mem_addr_o),
    .ld_ack_o   (ld_ack_o),
    .if_ack_o   (if_ack_o)
);

//--- src/smt_mem_path.sv
// --------------------------------------
// Top of the SMT memory path. Thread data
// requests and fetch share one memory
// port, and retired WFIs gate dispatch.
// Plain ports only, for the core and TB
// --------------------------------------
`timescale 1ns/1ps

module smt_mem_path #(
    parameter int THREAD_NUM = smt_mem_pkg::THREAD_NUM_DEF,
    parameter int RT_NUM     = smt_mem_pkg::RT_NUM_DEF
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                exception_i,
    // Thread data requests
    input  logic               [THREAD_NUM-1:0] ld_req_i,
    input  logic               [THREAD_NUM-1:0] ld_we_i,
    input  smt_mem_pkg::addr_t [THREAD_NUM-1:0] ld_addr_i,
    input  smt_mem_pkg::data_t [THREAD_NUM-1:0] ld_wdata_i,
    output logic               [THREAD_NUM-1:0] ld_ack_o,
    output smt_mem_pkg::data_t                  ld_rdata_o,
    // Instruction fetch, read only
    input  logic                                if_req_i,
    input  smt_mem_pkg::addr_t                  if_addr_i,
    output logic                                if_ack_o,
    output smt_mem_pkg::data_t                  if_rdata_o,
    // External memory
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output smt_mem_pkg::addr_t                  mem_addr_o,
    output smt_mem_pkg::data_t                  mem_wdata_o,
    input  logic                                mem_ack_i,
    input  smt_mem_pkg::data_t                  mem_rdata_i,
    // Retire and dispatch control
    input  logic [THREAD_NUM-1:0][RT_NUM-1:0]   rt_valid_i,
    input  logic [THREAD_NUM-1:0][RT_NUM-1:0]   rt_wfi_i,
    output logic [THREAD_NUM-1:0]               dp_en_o
);

    mem_req_if data_if ();   // Arbiter to switch
    mem_req_if fetch_if ();  // Fetch ports to switch

    // Fetch side requester
    assign fetch_if.req   = if_req_i;
    assign fetch_if.addr  = if_addr_i;
    assign fetch_if.we    = 1'b0;   // Fetch never writes
    assign fetch_if.wdata = '0;
    assign if_ack_o       = fetch_if.ack;
    assign if_rdata_o     = fetch_if.rdata;

    thread_mem_arbiter #(
        .THREAD_NUM (THREAD_NUM)
    ) i_thread_arb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ld_req_i   (ld_req_i),
        .ld_we_i    (ld_we_i),
        .ld_addr_i  (ld_addr_i),
        .ld_wdata_i (ld_wdata_i),
        .ld_ack_o   (ld_ack_o),
        .ld_rdata_o (ld_rdata_o),
        .data_if    (data_if.requester)
    );

    mem_port_switch i_port_sw (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .data_if     (data_if.responder),
        .fetch_if    (fetch_if.responder),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    wfi_tracker #(
        .THREAD_NUM (THREAD_NUM),
        .RT_NUM     (RT_NUM)
    ) i_wfi (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .exception_i (exception_i),
        .rt_valid_i  (rt_valid_i),
        .rt_wfi_i    (rt_wfi_i),
        .dp_en_o     (dp_en_o)
    );

endmodule

//--- src/wfi_tracker.sv
// --------------------------------------
// Per-thread WFI tracking. A retiring WFI
// stops dispatch at once and a sticky
// flag keeps it stopped until exception
// --------------------------------------
`timescale 1ns/1ps

module wfi_tracker #(
    parameter int THREAD_NUM = smt_mem_pkg::THREAD_NUM_DEF,
    parameter int RT_NUM     = smt_mem_pkg::RT_NUM_DEF
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               exception_i,  // Clears every flag
    input  logic [THREAD_NUM-1:0][RT_NUM-1:0]  rt_valid_i,
    input  logic [THREAD_NUM-1:0][RT_NUM-1:0]  rt_wfi_i,
    output logic [THREAD_NUM-1:0]              dp_en_o
);

    logic [THREAD_NUM-1:0] wfi_retire;  // WFI retiring this cycle
    logic [THREAD_NUM-1:0] wfi_flag_q;  // WFI retired earlier

    // Any valid lane carrying a WFI
    always_comb begin
        for (int unsigned th = 0; th < THREAD_NUM; th++) begin
            wfi_retire[th] = |(rt_valid_i[th] & rt_wfi_i[th]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wfi_flag_q <= '0;
        end else if (exception_i) begin
            wfi_flag_q <= '0;                       // Wake all threads
        end else begin
            wfi_flag_q <= wfi_flag_q | wfi_retire;  // Sticky set
        end
    end

    // Low in the retire cycle and after
    assign dp_en_o = ~(wfi_retire | wfi_flag_q);

endmodule

//--- src/mem_port_switch.sv
// --------------------------------------
// Shares the external memory port between
// the data channel and instruction fetch.
// Ties go to the side not served last,
// data side first out of reset
// --------------------------------------
`timescale 1ns/1ps

module mem_port_switch (
    input  logic               clk_i,
    input  logic               rst_n_i,
    mem_req_if.responder       data_if,
    mem_req_if.responder       fetch_if,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output smt_mem_pkg::addr_t mem_addr_o,
    output smt_mem_pkg::data_t mem_wdata_o,
    input  logic               mem_ack_i,
    input  smt_mem_pkg::data_t mem_rdata_i
);

    smt_mem_pkg::arb_state_e state_q;
    smt_mem_pkg::arb_state_e state_d;
    smt_mem_pkg::port_sel_e  owner_q;       // Side holding the port
    smt_mem_pkg::port_sel_e  owner_d;
    logic                    last_fetch_q;  // Fetch was served last
    logic                    own_req;
    logic                    busy;

    // ----------------------------------------
    // Owner pick
    // ----------------------------------------
    always_comb begin
        owner_d = owner_q;
        if (data_if.req && fetch_if.req) begin
            // Alternate on collision
            owner_d = last_fetch_q ? smt_mem_pkg::PORT_DATA : smt_mem_pkg::PORT_FETCH;
        end else if (fetch_if.req) begin
            owner_d = smt_mem_pkg::PORT_FETCH;
        end else if (data_if.req) begin
            owner_d = smt_mem_pkg::PORT_DATA;
        end
    end

    // ----------------------------------------
    // Memory side
    // ----------------------------------------
    assign busy    = (state_q != smt_mem_pkg::IDLE);
    assign own_req = (owner_q == smt_mem_pkg::PORT_FETCH) ? fetch_if.req : data_if.req;

    always_comb begin
        mem_req_o = 1'b0;
        case (state_q)
            smt_mem_pkg::BUSY:    mem_req_o = own_req;
            smt_mem_pkg::RELEASE: mem_req_o = own_req && mem_ack_i;   // Drop stays dropped
            default:              mem_req_o = 1'b0;
        endcase
    end

    always_comb begin
        if (owner_q == smt_mem_pkg::PORT_FETCH) begin
            mem_we_o    = fetch_if.we;
            mem_addr_o  = fetch_if.addr;
            mem_wdata_o = fetch_if.wdata;
        end else begin
            mem_we_o    = data_if.we;
            mem_addr_o  = data_if.addr;
            mem_wdata_o = data_if.wdata;
        end
    end

    // Ack and read data routed to the owner only
    assign data_if.ack    = busy && (owner_q == smt_mem_pkg::PORT_DATA) && mem_ack_i;
    assign fetch_if.ack   = busy && (owner_q == smt_mem_pkg::PORT_FETCH) && mem_ack_i;
    assign data_if.rdata  = (owner_q == smt_mem_pkg::PORT_DATA) ? mem_rdata_i : '0;
    assign fetch_if.rdata = (owner_q == smt_mem_pkg::PORT_FETCH) ? mem_rdata_i : '0;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            smt_mem_pkg::IDLE:    if (data_if.req || fetch_if.req) state_d = smt_mem_pkg::BUSY;
            smt_mem_pkg::BUSY:    if (mem_ack_i) state_d = smt_mem_pkg::RELEASE;
            smt_mem_pkg::RELEASE: if (!mem_req_o && !mem_ack_i) state_d = smt_mem_pkg::IDLE;
            default:              state_d = smt_mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= smt_mem_pkg::IDLE;
            owner_q      <= smt_mem_pkg::PORT_DATA;
            last_fetch_q <= 1'b1;                   // Data wins the first tie
        end else begin
            state_q <= state_d;
            if (state_q == smt_mem_pkg::IDLE) begin
                owner_q <= owner_d;
            end
            if (state_q == smt_mem_pkg::RELEASE && state_d == smt_mem_pkg::IDLE) begin
                last_fetch_q <= (owner_q == smt_mem_pkg::PORT_FETCH);
            end
        end
    end

endmodule

//--- src/thread_mem_arbiter.sv
// --------------------------------------
// Round-robin arbiter of per-thread data
// requests onto the single data channel.
// Grant is held for the whole four-phase
// exchange and rotates after each one
// --------------------------------------
`timescale 1ns/1ps

module thread_mem_arbiter #(
    parameter int THREAD_NUM = smt_mem_pkg::THREAD_NUM_DEF
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic               [THREAD_NUM-1:0] ld_req_i,
    input  logic               [THREAD_NUM-1:0] ld_we_i,
    input  smt_mem_pkg::addr_t [THREAD_NUM-1:0] ld_addr_i,
    input  smt_mem_pkg::data_t [THREAD_NUM-1:0] ld_wdata_i,
    output logic               [THREAD_NUM-1:0] ld_ack_o,
    output smt_mem_pkg::data_t                  ld_rdata_o,   // Shared, qualified by ack
    mem_req_if.requester                        data_if
);

    localparam int IDX_W = (THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1;

    smt_mem_pkg::arb_state_e state_q;
    smt_mem_pkg::arb_state_e state_d;
    logic [IDX_W-1:0]        gnt_q;     // Thread owning the channel
    logic [IDX_W-1:0]        gnt_d;
    logic [IDX_W-1:0]        last_q;    // Thread served last
    logic                    any_req;
    logic                    sel_req;

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    // Search starts one past the last served thread
    always_comb begin
        int unsigned idx;
        gnt_d   = gnt_q;
        any_req = 1'b0;
        for (int unsigned i = 1; i <= THREAD_NUM; i++) begin
            idx = (last_q + i) % THREAD_NUM;
            if (!any_req && ld_req_i[idx]) begin
                gnt_d   = idx[IDX_W-1:0];
                any_req = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Forwarding onto the data channel
    // ----------------------------------------
    assign sel_req = ld_req_i[gnt_q];

    always_comb begin
        data_if.req = 1'b0;                                 // Nothing forwarded in IDLE
        case (state_q)
            smt_mem_pkg::BUSY:    data_if.req = sel_req;
            smt_mem_pkg::RELEASE: data_if.req = sel_req && data_if.ack;  // No re-request
            default:              data_if.req = 1'b0;
        endcase
    end

    assign data_if.addr  = ld_addr_i[gnt_q];
    assign data_if.we    = ld_we_i[gnt_q];
    assign data_if.wdata = ld_wdata_i[gnt_q];

    // Ack goes back to the granted thread only
    always_comb begin
        ld_ack_o = '0;
        if (state_q != smt_mem_pkg::IDLE) begin
            ld_ack_o[gnt_q] = data_if.ack;
        end
    end

    assign ld_rdata_o = data_if.rdata;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            smt_mem_pkg::IDLE:    if (any_req) state_d = smt_mem_pkg::BUSY;
            smt_mem_pkg::BUSY:    if (data_if.ack) state_d = smt_mem_pkg::RELEASE;
            smt_mem_pkg::RELEASE: if (!data_if.req && !data_if.ack) state_d = smt_mem_pkg::IDLE;
            default:              state_d = smt_mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= smt_mem_pkg::IDLE;
            gnt_q   <= '0;
            last_q  <= IDX_W'(THREAD_NUM - 1);  // Thread 0 first after reset
        end else begin
            state_q <= state_d;
            if (state_q == smt_mem_pkg::IDLE && any_req) begin
                gnt_q <= gnt_d;                 // Latched once per exchange
            end
            if (state_q == smt_mem_pkg::RELEASE && state_d == smt_mem_pkg::IDLE) begin
                last_q <= gnt_q;
            end
        end
    end

endmodule

//--- src/mem_req_if.sv
// --------------------------------------
// Four-phase request channel between the
// arbiter, the port switch and fetch.
// Requester drives req and payload, the
// responder answers with ack and rdata
// --------------------------------------
`timescale 1ns/1ps

interface mem_req_if;

    logic               req;    // Held until ack seen
    logic               ack;    // Held until req drops
    smt_mem_pkg::addr_t addr;
    logic               we;     // 1 for store
    smt_mem_pkg::data_t wdata;
    smt_mem_pkg::data_t rdata;  // Valid while ack high on a read

    modport requester (
        output req,
        output addr,
        output we,
        output wdata,
        input  ack,
        input  rdata
    );

    modport responder (
        input  req,
        input  addr,
        input  we,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- src/smt_mem_pkg.sv
// --------------------------------------
// Shared sizes, types and state encodings
// for the SMT memory path. Referenced by
// scoped name from the RTL and testbench
// --------------------------------------
package smt_mem_pkg;

    // ----------------------------------------
    // Default sizes
    // ----------------------------------------
    parameter int THREAD_NUM_DEF = 2;   // Hardware threads
    parameter int RT_NUM_DEF     = 2;   // Retire lanes per thread

    parameter int ADDR_W = 32;          // Byte address width
    parameter int DATA_W = 64;          // Memory word width

    // ----------------------------------------
    // Payload types
    // ----------------------------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // ----------------------------------------
    // State encodings
    // ----------------------------------------
    // Shared by the thread arbiter and the port switch
    typedef enum logic [1:0] {
        IDLE    = 2'd0,     // No grant held
        BUSY    = 2'd1,     // Granted request outstanding
        RELEASE = 2'd2      // Handshake returning to zero
    } arb_state_e;

    // Owner of the external memory port
    typedef enum logic {
        PORT_DATA  = 1'b0,
        PORT_FETCH = 1'b1
    } port_sel_e;

endpackage
